/* compile.f */
ps2Pkg.sv
ps2ClockFilter.sv
ps2FrameReceiver.sv
scanTranslator.sv
keyFifo.sv
keyboardRegs.sv
ps2Keyboard.sv
tbPs2Keyboard.sv

/* keyFifo.sv */
`timescale 1ns/10ps

module keyFifo #(
    parameter int fifoDepth = 4
) (
    input  logic             clk25,
    input  logic             rst,
    input  ps2Pkg::keyEntryT keyPush,
    input  logic             pop,
    output ps2Pkg::keyEntryT head,
    output logic             creditReturn
);

    localparam int ptrW   = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
    localparam int countW = $clog2(fifoDepth + 1);

    logic [7:0]        mem [fifoDepth];
    logic [ptrW-1:0]   wrPtr;
    logic [ptrW-1:0]   rdPtr;
    logic [countW-1:0] count;
    logic              doPop;

    // full never happens, the translator holds the credits
    assign doPop = pop && (count != '0);

    assign head         = '{valid: count != '0, ascii: mem[rdPtr]};
    assign creditReturn = doPop;

    always_ff @(posedge clk25)
    begin
        if (keyPush.valid)
            mem[wrPtr] <= keyPush.ascii;
    end

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (keyPush.valid)
                wrPtr <= (wrPtr == ptrW'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            if (doPop)
                rdPtr <= (rdPtr == ptrW'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;

            case ({keyPush.valid, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

endmodule

/* keyboardCases.txt */
# op arg: K code good frame, P code bad parity frame, D hex expect at address 0
# S hex expect at address 1, W poll until not empty, T name end of test
K 1C
K F0
K 1C
K 16
K F0
K 16
K 4E
K F0
K 4E
W
D 41
D 31
D 2D
D 00
T unshifted
K 12
K 16
K 5D
K F0
K 12
K 16
W
D 21
D 7C
D 31
T shift
K F0
K 1C
K E0
K 75
K E0
K F0
K 75
S 00
T prefixes
P 1C
S 20
S 00
K 1C
W
D 41
S 00
T framing
K 1C
K 32
K 21
K 23
K 24
K 2B
S C0
D 41
D 42
D 43
D 44
S 00
T credits

/* keyboardRegs.sv */
`timescale 1ns/10ps

module keyboardRegs (
    input  logic             clk25,
    input  logic             rst,
    input  logic             cs,
    input  logic             address,
    input  ps2Pkg::keyEntryT head,
    input  logic             overflow,
    input  logic             frameError,
    output logic             pop,
    output logic [7:0]       dout
);

    ps2Pkg::statusT status;
    logic           statusRead;
    logic           overflowFlag;
    logic           frameErrorFlag;

    assign statusRead = cs & address;
    assign pop        = cs & ~address & head.valid;    // data read consumes the head

    assign status = '{notEmpty:   head.valid,
                      overflow:   overflowFlag,
                      frameError: frameErrorFlag,
                      reserved:   5'd0};

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            dout           <= 8'h00;
            overflowFlag   <= 1'b0;
            frameErrorFlag <= 1'b0;
        end
        else
        begin
            if (cs)
            begin
                if (address)
                    dout <= status;
                else
                    dout <= head.valid ? head.ascii : 8'h00;
            end

            // a new event beats the clear of a status read
            overflowFlag   <= overflow | (overflowFlag & ~statusRead);
            frameErrorFlag <= frameError | (frameErrorFlag & ~statusRead);
        end
    end

endmodule

/* ps2ClockFilter.sv */
`timescale 1ns/10ps

module ps2ClockFilter #(
    parameter int filterCycles = 8
) (
    input  logic clk25,
    input  logic rst,
    input  logic keyClk,
    output logic clkFall
);

    localparam int cntW = $clog2(filterCycles + 1);

    logic [1:0]      clkSync;       // two-stage synchronizer
    logic            level;         // accepted clock level
    logic [cntW-1:0] sampleCount;

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            clkSync     <= 2'b11;
            level       <= 1'b1;    // ps2 clock idles high
            sampleCount <= '0;
            clkFall     <= 1'b0;
        end
        else
        begin
            clkSync <= {clkSync[0], keyClk};
            clkFall <= 1'b0;
            if (clkSync[1] == level)
                sampleCount <= '0;  // glitch gone, start over
            else if (sampleCount == cntW'(filterCycles - 1))
            begin
                // enough identical samples, take the new level
                level       <= clkSync[1];
                sampleCount <= '0;
                clkFall     <= level & ~clkSync[1];
            end
            else
                sampleCount <= sampleCount + 1'b1;
        end
    end

endmodule

/* ps2FrameReceiver.sv */
`timescale 1ns/10ps

module ps2FrameReceiver #(
    parameter int filterCycles = 8
) (
    input  logic              clk25,
    input  logic              rst,
    input  logic              keyClk,
    input  logic              keyDin,
    output ps2Pkg::scanEventT scanEvent,
    output logic              frameError
);

    // no falling edge for 100 us means the frame was abandoned
    localparam int idleCycles = 2500;
    localparam int idleW      = $clog2(idleCycles + 1);

    logic             clkFall;
    logic [1:0]       dinSync;
    logic [10:0]      shiftReg;     // stop, parity, data[7:0], start
    logic [3:0]       bitCount;
    logic [idleW-1:0] idleCount;
    logic             frameReady;   // full frame sits in shiftReg
    logic             frameOk;

    ps2ClockFilter #(
        .filterCycles(filterCycles)
    ) clockFilter (
        .clk25  (clk25),
        .rst    (rst),
        .keyClk (keyClk),
        .clkFall(clkFall)
    );

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
            dinSync <= 2'b11;
        else
            dinSync <= {dinSync[0], keyDin};
    end

    // lsb first, so the start bit ends up in bit 0
    always_ff @(posedge clk25)
    begin
        if (clkFall)
            shiftReg <= {dinSync[1], shiftReg[10:1]};
    end

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            bitCount   <= '0;
            idleCount  <= '0;
            frameReady <= 1'b0;
        end
        else
        begin
            frameReady <= 1'b0;
            if (clkFall)
            begin
                idleCount <= '0;
                if (bitCount == 4'd10)
                begin
                    bitCount   <= '0;
                    frameReady <= 1'b1;
                end
                else
                    bitCount <= bitCount + 4'd1;
            end
            else if (bitCount != 4'd0)
            begin
                // partial frame, watch for a stalled clock
                if (idleCount == idleW'(idleCycles - 1))
                begin
                    bitCount  <= '0;
                    idleCount <= '0;
                end
                else
                    idleCount <= idleCount + 1'b1;
            end
        end
    end

    // start low, stop high, odd parity over data and parity bit
    assign frameOk = ~shiftReg[0] & shiftReg[10] & (^shiftReg[9:1]);

    assign scanEvent  = '{valid: frameReady & frameOk, code: shiftReg[8:1]};
    assign frameError = frameReady & ~frameOk;

endmodule

/* ps2Keyboard.sv */
`timescale 1ns/10ps

module ps2Keyboard #(
    parameter int fifoDepth    = 4,
    parameter int filterCycles = 8
) (
    input  logic       clk25,
    input  logic       rst,
    input  logic       keyClk,
    input  logic       keyDin,
    input  logic       cs,
    input  logic       address,
    output logic [7:0] dout
);

    ps2Pkg::scanEventT scanEvent;
    ps2Pkg::keyEntryT  keyPush;
    ps2Pkg::keyEntryT  head;
    logic              frameError;
    logic              overflow;
    logic              pop;
    logic              creditReturn;

    ps2FrameReceiver #(
        .filterCycles(filterCycles)
    ) receiver (
        .clk25     (clk25),
        .rst       (rst),
        .keyClk    (keyClk),
        .keyDin    (keyDin),
        .scanEvent (scanEvent),
        .frameError(frameError)
    );

    scanTranslator #(
        .fifoDepth(fifoDepth)
    ) translator (
        .clk25       (clk25),
        .rst         (rst),
        .scanEvent   (scanEvent),
        .creditReturn(creditReturn),
        .keyPush     (keyPush),
        .overflow    (overflow)
    );

    keyFifo #(
        .fifoDepth(fifoDepth)
    ) fifo (
        .clk25       (clk25),
        .rst         (rst),
        .keyPush     (keyPush),
        .pop         (pop),
        .head        (head),
        .creditReturn(creditReturn)
    );

    keyboardRegs regs (
        .clk25     (clk25),
        .rst       (rst),
        .cs        (cs),
        .address   (address),
        .head      (head),
        .overflow  (overflow),
        .frameError(frameError),
        .pop       (pop),
        .dout      (dout)
    );

endmodule

/* ps2Pkg.sv */
package ps2Pkg;

    // one scan code as received from the keyboard
    typedef struct packed
    {
        logic       valid;
        logic [7:0] code;
    } scanEventT;

    // one translated character on its way into the FIFO
    typedef struct packed
    {
        logic       valid;
        logic [7:0] ascii;
    } keyEntryT;

    // status byte as seen by the CPU at address 1, msb first
    typedef struct packed
    {
        logic       notEmpty;   // bit 7
        logic       overflow;   // bit 6
        logic       frameError; // bit 5
        logic [4:0] reserved;
    } statusT;

    // scan code set 2 prefixes
    localparam logic [7:0] codeBreak  = 8'hF0;
    localparam logic [7:0] codeExtend = 8'hE0;

    localparam logic [7:0] codeShiftLeft  = 8'h12;
    localparam logic [7:0] codeShiftRight = 8'h59;

    // sent for keys without a mapping
    localparam logic [7:0] asciiUnknown = 8'h2E;

endpackage

/* runSim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps -f compile.f \
    --top-module tbPs2Keyboard -o simKeyboard
output=$(./obj_dir/simKeyboard)
echo "$output"
if echo "$output" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1

/* scanTranslator.sv */
`timescale 1ns/10ps

module scanTranslator #(
    parameter int fifoDepth = 4
) (
    input  logic              clk25,
    input  logic              rst,
    input  ps2Pkg::scanEventT scanEvent,
    input  logic              creditReturn,
    output ps2Pkg::keyEntryT  keyPush,
    output logic              overflow
);

    localparam int creditW = $clog2(fifoDepth + 1);

    typedef enum logic [1:0]
    {
        stNormal,
        stBreak,
        stExtended,
        stExtendedBreak
    } stateT;

    stateT              state;
    logic               shift;
    logic [creditW-1:0] credits;
    logic [7:0]         asciiCode;
    logic               isShiftCode;
    logic               press;      // a key that yields a character
    logic               spend;

    assign isShiftCode = (scanEvent.code == ps2Pkg::codeShiftLeft)
                      || (scanEvent.code == ps2Pkg::codeShiftRight);

    assign press = scanEvent.valid && (state == stNormal)
                && (scanEvent.code != ps2Pkg::codeBreak)
                && (scanEvent.code != ps2Pkg::codeExtend)
                && !isShiftCode;

    assign spend = press && (credits != '0);

    // US layout, letters are always upper case
    always_comb
    begin
        asciiCode = ps2Pkg::asciiUnknown;
        case (scanEvent.code)
            8'h1C: asciiCode = "A";
            8'h32: asciiCode = "B";
            8'h21: asciiCode = "C";
            8'h23: asciiCode = "D";
            8'h24: asciiCode = "E";
            8'h2B: asciiCode = "F";
            8'h34: asciiCode = "G";
            8'h33: asciiCode = "H";
            8'h43: asciiCode = "I";
            8'h3B: asciiCode = "J";
            8'h42: asciiCode = "K";
            8'h4B: asciiCode = "L";
            8'h3A: asciiCode = "M";
            8'h31: asciiCode = "N";
            8'h44: asciiCode = "O";
            8'h4D: asciiCode = "P";
            8'h15: asciiCode = "Q";
            8'h2D: asciiCode = "R";
            8'h1B: asciiCode = "S";
            8'h2C: asciiCode = "T";
            8'h3C: asciiCode = "U";
            8'h2A: asciiCode = "V";
            8'h1D: asciiCode = "W";
            8'h22: asciiCode = "X";
            8'h35: asciiCode = "Y";
            8'h1A: asciiCode = "Z";
            8'h45: asciiCode = shift ? ")" : "0";
            8'h16: asciiCode = shift ? "!" : "1";
            8'h1E: asciiCode = shift ? "@" : "2";
            8'h26: asciiCode = shift ? "#" : "3";
            8'h25: asciiCode = shift ? "$" : "4";
            8'h2E: asciiCode = shift ? "%" : "5";
            8'h36: asciiCode = shift ? "^" : "6";
            8'h3D: asciiCode = shift ? "&" : "7";
            8'h3E: asciiCode = shift ? "*" : "8";
            8'h46: asciiCode = shift ? "(" : "9";
            8'h4E: asciiCode = shift ? "_" : "-";
            8'h55: asciiCode = shift ? "+" : "=";
            8'h5D: asciiCode = shift ? "|" : 8'h5C;    // backslash
            8'h54: asciiCode = shift ? "{" : "[";
            8'h5B: asciiCode = shift ? "}" : "]";
            8'h4C: asciiCode = shift ? ":" : ";";
            8'h52: asciiCode = shift ? "\"" : "'";
            8'h41: asciiCode = shift ? "<" : ",";
            8'h49: asciiCode = shift ? ">" : ".";
            8'h4A: asciiCode = shift ? "?" : "/";
            8'h66: asciiCode = 8'h08;                   // backspace
            8'h5A: asciiCode = 8'h0D;                   // enter
            8'h29: asciiCode = " ";
            default: asciiCode = ps2Pkg::asciiUnknown;
        endcase
    end

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            state    <= stNormal;
            shift    <= 1'b0;
            credits  <= creditW'(fifoDepth);   // FIFO starts empty
            keyPush  <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            keyPush  <= '{valid: spend, ascii: asciiCode};
            overflow <= press && (credits == '0);   // no room, drop it

            case ({spend, creditReturn})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase

            if (scanEvent.valid)
            begin
                case (state)
                    stNormal:
                    begin
                        if (scanEvent.code == ps2Pkg::codeBreak)
                            state <= stBreak;
                        else if (scanEvent.code == ps2Pkg::codeExtend)
                            state <= stExtended;
                        else if (isShiftCode)
                            shift <= 1'b1;
                    end
                    stBreak:
                    begin
                        if (isShiftCode)
                            shift <= 1'b0;
                        state <= stNormal;
                    end
                    stExtended:
                        // extended keys are ignored, only the release prefix matters
                        state <= (scanEvent.code == ps2Pkg::codeBreak) ? stExtendedBreak
                                                                       : stNormal;
                    default:
                        state <= stNormal;
                endcase
            end
        end
    end

endmodule

/* tbPs2Keyboard.sv */
`timescale 1ns/10ps

module tbPs2Keyboard;

    localparam int halfPeriod = 40;     // clk25 cycles per ps2 clock half
    localparam int idleGap    = 200;    // quiet time between frames

    logic       clk25 = 1'b0;
    logic       rst;
    logic       keyClk;
    logic       keyDin;
    logic       cs;
    logic       address;
    logic [7:0] dout;

    int cycleCount = 0;
    int cycleLimit = 2000;
    int passCount  = 0;
    int failCount  = 0;
    int testErrors = 0;

    ps2Keyboard #(
        .fifoDepth   (4),
        .filterCycles(8)
    ) uut (
        .clk25  (clk25),
        .rst    (rst),
        .keyClk (keyClk),
        .keyDin (keyDin),
        .cs     (cs),
        .address(address),
        .dout   (dout)
    );

    always #2 clk25 = ~clk25;

    // ends a stuck run once the limit from the cases file length is reached
    always @(posedge clk25)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("run timed out after %0d cycles", cycleCount);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk25);
    endtask

    // start, 8 data bits lsb first, parity, stop
    task automatic sendFrame(input logic [7:0] code, input logic badParity);
        logic [10:0] bits;
        int          gap;
        bits = {1'b1, (~^code) ^ badParity, code, 1'b0};
        @(posedge clk25);
        for (int i = 0; i < 11; i++)
        begin
            keyDin <= bits[i];          // data moves while keyClk is high
            waitCycles(halfPeriod);
            keyClk <= 1'b0;
            waitCycles(halfPeriod);
            keyClk <= 1'b1;
        end
        keyDin <= 1'b1;
        gap = idleGap + int'($urandom % 8);
        waitCycles(gap);
    endtask

    // one cycle of cs with dout sampled half a cycle after it updates
    task automatic readRegister(input logic addr, output logic [7:0] value);
        @(posedge clk25);
        cs      <= 1'b1;
        address <= addr;
        @(posedge clk25);
        cs <= 1'b0;
        @(negedge clk25);
        value = dout;
    endtask

    task automatic expectRead(input logic addr, input logic [7:0] expected);
        logic [7:0] value;
        readRegister(addr, value);
        if (value !== expected)
        begin
            $display("ERROR: dout at address %0d expected %h got %h", addr, expected, value);
            testErrors++;
        end
    endtask

    task automatic pollNotEmpty();
        logic [7:0] value;
        do
            readRegister(1'b1, value);
        while (!value[7]);              // bit 7 is notEmpty
    endtask

    initial
    begin
        int             fd;
        int             r;
        int             lineCount;
        int unsigned    seedDummy;
        logic           done;
        logic [7:0]     op;
        logic [7:0]     arg;
        logic [127:0]   testName;
        logic [639:0]   lineBuf;

        seedDummy = $urandom(54);
        rst     <= 1'b1;
        keyClk  <= 1'b1;                // ps2 lines idle high
        keyDin  <= 1'b1;
        cs      <= 1'b0;
        address <= 1'b0;

        lineCount = 0;
        fd = $fopen("keyboardCases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open keyboardCases.txt");
            testErrors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                r = $fgets(lineBuf, fd);
                if (r > 0)
                    lineCount++;
            end
            $fclose(fd);
            cycleLimit = lineCount * 1200 + 2000;
            fd = $fopen("keyboardCases.txt", "r");
        end

        waitCycles(16);
        rst <= 1'b0;
        waitCycles(4);

        done = (fd == 0);
        while (!done)
        begin
            r = $fscanf(fd, "%s", op);
            if (r != 1)
                done = 1'b1;
            else
            begin
                case (op)
                    "#":
                        r = $fgets(lineBuf, fd);  // rest of a comment line
                    "K", "P":
                    begin
                        r = $fscanf(fd, "%h", arg);
                        sendFrame(arg, op == "P");
                    end
                    "D", "S":
                    begin
                        r = $fscanf(fd, "%h", arg);
                        expectRead(op == "S", arg);
                    end
                    "W":
                        pollNotEmpty();
                    "T":
                    begin
                        r = $fscanf(fd, "%s", testName);
                        if (testErrors == 0)
                        begin
                            $display("test %0s passed", testName);
                            passCount++;
                        end
                        else
                        begin
                            $display("test %0s failed with %0d errors", testName, testErrors);
                            failCount++;
                        end
                        testErrors = 0;
                    end
                    default:
                    begin
                        $display("unknown operation in cases file");
                        testErrors++;
                    end
                endcase
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("tests passed %0d, tests failed %0d", passCount, failCount);
        if (failCount == 0 && testErrors == 0 && passCount > 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
